//--- Makefile
TOP := tb_gemm_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

//--- gemm_cfg_regs.sv
// GEMM job register bank with host writes, snapshot on trigger and start strobe
`timescale 1ns/1ps
`include "gemm_consts.svh"

module gemm_cfg_regs
  import gemm_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        reg_we_i,
  input  logic [3:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output job_regs_t   job_o,
  output logic        start_o
);

  // Host visible job words, the trigger index has no storage
  logic [31:0] regs_q [`REG_TRIGGER];
  logic        word_we;
  logic        trigger;
  job_regs_t   job_d;
  job_regs_t   job_q;
  logic        start_q;

  assign word_we = reg_we_i && (reg_addr_i < 4'(`REG_TRIGGER));
  assign trigger = reg_we_i && (reg_addr_i == 4'(`REG_TRIGGER));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `REG_TRIGGER; i++) begin
        regs_q[i] <= '0;
      end
    end else if (clear_i) begin
      for (int i = 0; i < `REG_TRIGGER; i++) begin
        regs_q[i] <= '0;
      end
    end else if (word_we) begin
      regs_q[reg_addr_i[2:0]] <= reg_wdata_i;
    end
  end

  // Field decode of the stored words
  always_comb begin
    job_d.x_addr  = regs_q[`REG_X_ADDR];
    job_d.w_addr  = regs_q[`REG_W_ADDR];
    job_d.z_addr  = regs_q[`REG_Z_ADDR];
    job_d.m_size  = regs_q[`REG_MCFG0][15:0];
    job_d.k_size  = regs_q[`REG_MCFG0][31:16];
    job_d.n_size  = regs_q[`REG_MCFG1][15:0];
    job_d.gemm_op = gemm_op_e'(regs_q[`REG_MACFG][12:10]);
    job_d.fmt     = gemm_fmt_e'(regs_q[`REG_MACFG][9:7]);
  end

  // Snapshot keeps the running job apart from later host writes
  always_ff @(posedge clk_i) begin
    if (trigger) begin
      job_q <= job_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
    end else if (clear_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= trigger;
    end
  end

  assign job_o   = job_q;
  assign start_o = start_q;

  // Host must stay inside the register map
  a_addr_in_map: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    reg_we_i |-> (reg_addr_i < 4'(`NUM_REGS))
  );

endmodule

//--- gemm_consts.svh
// GEMM controller constants for array geometry and job register indices
`ifndef GEMM_CONSTS_SVH
`define GEMM_CONSTS_SVH

// Systolic array geometry
// Rows of X handled by one tile
`define ARRAY_WIDTH 12
// Depth of one systolic column
`define ARRAY_HEIGHT 4
// Pipeline registers inside each processing element
`define PIPE_REGS 3
// Columns covered by one tile
`define COL_CHUNK ((`ARRAY_HEIGHT) * ((`PIPE_REGS) + 1))

// Job register word indices
`define REG_X_ADDR 0
`define REG_W_ADDR 1
`define REG_Z_ADDR 2
// k_size in the upper half, m_size in the lower half
`define REG_MCFG0 3
// n_size in the lower half
`define REG_MCFG1 4
// Operation and number format fields
`define REG_MACFG 5
// Any write here launches a job
`define REG_TRIGGER 6
`define NUM_REGS 7

`endif

//--- gemm_ctrl_top.sv
// GEMM controller top level joining register bank, tiler and store walker
`timescale 1ns/1ps
`include "gemm_consts.svh"

module gemm_ctrl_top
  import gemm_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        reg_we_i,
  input  logic [3:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic        cfg_valid_o,
  output tile_cfg_t   cfg_o,
  output logic        store_valid_o,
  output store_desc_t store_o,
  output logic        done_o,
  output logic        busy_o
);

  job_regs_t job;
  logic      start;

  gemm_cfg_regs i_gemm_cfg_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .job_o       (job),
    .start_o     (start)
  );

  gemm_tiler i_gemm_tiler (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .start_i     (start),
    .job_i       (job),
    .cfg_valid_o (cfg_valid_o),
    .cfg_o       (cfg_o)
  );

  // Walker reads the tiling result straight from the top outputs
  gemm_store_walker i_gemm_store_walker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .cfg_valid_i   (cfg_valid_o),
    .cfg_i         (cfg_o),
    .store_valid_o (store_valid_o),
    .store_o       (store_o),
    .done_o        (done_o),
    .busy_o        (busy_o)
  );

endmodule

//--- gemm_pkg.sv
// GEMM controller shared types for job registers, tile configuration and store descriptors
package gemm_pkg;

  // Operations offered by the engine
  typedef enum logic [2:0] {
    MATMUL,
    GEMM,
    ADDMAX,
    ADDMIN,
    MULMAX,
    MULMIN,
    MAXMIN
  } gemm_op_e;

  // Operand number formats
  typedef enum logic [2:0] {
    FP16,
    FP8,
    FP16ALT,
    FP8ALT
  } gemm_fmt_e;

  // Operations of the two FPU stages
  typedef enum logic [4:0] {
    FMADD,
    ADD,
    MUL,
    MINMAX
  } fpu_op_e;

  typedef enum logic [2:0] {
    RNE,
    RTZ
  } rnd_mode_e;

  // Snapshot of the host job registers
  typedef struct packed {
    logic [31:0] x_addr;
    logic [31:0] w_addr;
    logic [31:0] z_addr;
    logic [15:0] m_size;
    logic [15:0] k_size;
    logic [15:0] n_size;
    gemm_op_e    gemm_op;
    gemm_fmt_e   fmt;
  } job_regs_t;

  // Tiling result handed to the store walker
  typedef struct packed {
    logic [15:0] x_rows_iter;
    logic [15:0] x_cols_iter;
    logic [15:0] w_rows_iter;
    logic [15:0] w_cols_iter;
    logic [7:0]  x_rows_lftovr;
    logic [7:0]  x_cols_lftovr;
    logic [7:0]  w_rows_lftovr;
    logic [7:0]  w_cols_lftovr;
    logic [15:0] x_buffer_slots;
    logic [15:0] tot_stores;
    logic [31:0] tot_x_read;
    logic [31:0] w_tot_len;
    logic [31:0] z_tot_len;
    logic [31:0] x_d1_stride;
    logic [31:0] x_rows_offs;
    logic [31:0] w_d0_stride;
    logic [31:0] z_d2_stride;
    fpu_op_e     stage1_op;
    fpu_op_e     stage2_op;
    rnd_mode_e   stage1_rnd;
    rnd_mode_e   stage2_rnd;
    logic [1:0]  elem_bytes;
    logic        gemm_sel;
    logic [31:0] z_addr;
  } tile_cfg_t;

  // One output tile store
  typedef struct packed {
    logic [31:0] addr;
    logic [15:0] row_idx;
    logic [15:0] col_idx;
    logic        last;
  } store_desc_t;

endpackage

//--- gemm_store_walker.sv
// GEMM store walker stepping row-major over output tiles, one descriptor per cycle
`timescale 1ns/1ps
`include "gemm_consts.svh"

module gemm_store_walker
  import gemm_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        cfg_valid_i,
  input  tile_cfg_t   cfg_i,
  output logic        store_valid_o,
  output store_desc_t store_o,
  output logic        done_o,
  output logic        busy_o
);

  logic        busy_q;
  logic        store_valid_q;
  logic        done_q;
  store_desc_t store_q;
  store_desc_t first_store;
  store_desc_t next_store;
  // Address of column zero in the current tile row
  logic [31:0] row_base_q;
  logic [31:0] col_step;
  logic [15:0] last_row;
  logic [15:0] last_col;
  logic        row_wrap;

  always_comb begin
    col_step = 32'(`COL_CHUNK) * 32'(cfg_i.elem_bytes);
    last_row = cfg_i.x_rows_iter - 16'd1;
    last_col = cfg_i.w_cols_iter - 16'd1;

    first_store = '{
      addr:    cfg_i.z_addr,
      row_idx: 16'd0,
      col_idx: 16'd0,
      last:    (last_row == '0) && (last_col == '0)
    };

    // Next tile, wrapping to the next row at the last column
    row_wrap   = (store_q.col_idx == last_col);
    next_store = store_q;
    if (row_wrap) begin
      next_store.row_idx = store_q.row_idx + 16'd1;
      next_store.col_idx = 16'd0;
      next_store.addr    = row_base_q + cfg_i.z_d2_stride;
    end else begin
      next_store.col_idx = store_q.col_idx + 16'd1;
      next_store.addr    = store_q.addr + col_step;
    end
    next_store.last = (next_store.row_idx == last_row) && (next_store.col_idx == last_col);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q        <= 1'b0;
      store_valid_q <= 1'b0;
      done_q        <= 1'b0;
    end else if (clear_i) begin
      busy_q        <= 1'b0;
      store_valid_q <= 1'b0;
      done_q        <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (cfg_valid_i) begin
        // Empty job finishes at once
        if (cfg_i.tot_stores == '0) begin
          done_q <= 1'b1;
        end else begin
          busy_q        <= 1'b1;
          store_valid_q <= 1'b1;
        end
      end else if (store_valid_q && store_q.last) begin
        busy_q        <= 1'b0;
        store_valid_q <= 1'b0;
        done_q        <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_valid_i) begin
      store_q    <= first_store;
      row_base_q <= cfg_i.z_addr;
    end else if (store_valid_q) begin
      store_q <= next_store;
      if (row_wrap) begin
        row_base_q <= next_store.addr;
      end
    end
  end

  assign store_valid_o = store_valid_q;
  assign store_o       = store_q;
  assign done_o        = done_q;
  assign busy_o        = busy_q;

  a_store_in_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    store_valid_o |-> busy_o
  );

  // A new tiling result while walking means the host triggered too early
  a_no_cfg_while_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cfg_valid_i |-> !busy_o
  );

endmodule

//--- gemm_tiler.sv
// GEMM tiler computing tile counts, leftovers, strides, lengths and FPU operation decode
`timescale 1ns/1ps
`include "gemm_consts.svh"

module gemm_tiler
  import gemm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      start_i,
  input  job_regs_t job_i,
  output logic      cfg_valid_o,
  output tile_cfg_t cfg_o
);

  tile_cfg_t   cfg_d;
  tile_cfg_t   cfg_q;
  logic        cfg_valid_q;

  // Whole tiles along each dimension, before rounding up
  logic [15:0] x_rows_div;
  logic [15:0] x_cols_div;
  logic [15:0] w_cols_div;
  logic [15:0] w_rows_div;
  logic [15:0] w_rows_lft;
  logic [15:0] slots_div;

  // Product pipeline, each stage with its own valid
  logic [31:0] rows_cols_q;
  logic        rows_cols_valid_q;
  logic [31:0] x_read_q;
  logic        x_read_valid_q;
  logic [31:0] w_len_q;
  logic        w_len_valid_q;
  logic        load_cfg;

  always_comb begin
    x_rows_div = job_i.m_size / 16'(`ARRAY_WIDTH);
    x_cols_div = job_i.n_size / 16'(`COL_CHUNK);
    w_cols_div = job_i.k_size / 16'(`COL_CHUNK);
    w_rows_div = job_i.n_size / 16'(`ARRAY_HEIGHT);

    cfg_d.x_rows_lftovr = 8'(job_i.m_size - x_rows_div * 16'(`ARRAY_WIDTH));
    cfg_d.x_cols_lftovr = 8'(job_i.n_size - x_cols_div * 16'(`COL_CHUNK));
    cfg_d.w_cols_lftovr = 8'(job_i.k_size - w_cols_div * 16'(`COL_CHUNK));
    w_rows_lft          = job_i.n_size - w_rows_div * 16'(`ARRAY_HEIGHT);
    cfg_d.w_rows_lftovr = 8'(w_rows_lft);

    // Partial tiles count as one more iteration
    cfg_d.x_rows_iter = (cfg_d.x_rows_lftovr != '0) ? x_rows_div + 16'd1 : x_rows_div;
    cfg_d.x_cols_iter = (cfg_d.x_cols_lftovr != '0) ? x_cols_div + 16'd1 : x_cols_div;
    cfg_d.w_cols_iter = (cfg_d.w_cols_lftovr != '0) ? w_cols_div + 16'd1 : w_cols_div;
    // W rows padded up to the column depth
    cfg_d.w_rows_iter = (w_rows_lft != '0) ?
                        job_i.n_size + 16'(`ARRAY_HEIGHT) - w_rows_lft : job_i.n_size;

    slots_div = (16'(cfg_d.x_cols_lftovr) + 16'(`ARRAY_HEIGHT) - 16'd1) / 16'(`ARRAY_HEIGHT);
    cfg_d.x_buffer_slots = slots_div * 16'(`ARRAY_HEIGHT);

    // Totals come from the product pipeline
    cfg_d.tot_stores = rows_cols_q[15:0];
    cfg_d.tot_x_read = x_read_q;
    cfg_d.w_tot_len  = w_len_q;
    cfg_d.z_tot_len  = 32'(`ARRAY_WIDTH) * 32'(cfg_d.tot_stores);

    cfg_d.elem_bytes = (job_i.fmt == FP16 || job_i.fmt == FP16ALT) ? 2'd2 : 2'd1;

    // Byte strides
    cfg_d.x_d1_stride = 32'(job_i.n_size) * 32'(cfg_d.elem_bytes);
    cfg_d.x_rows_offs = 32'(`ARRAY_WIDTH) * cfg_d.x_d1_stride;
    cfg_d.w_d0_stride = 32'(job_i.k_size) * 32'(cfg_d.elem_bytes);
    cfg_d.z_d2_stride = 32'(`ARRAY_WIDTH) * cfg_d.w_d0_stride;

    // Operation decode
    cfg_d.stage2_op = MINMAX;
    cfg_d.gemm_sel  = (job_i.gemm_op != MATMUL);
    case (job_i.gemm_op)
      MATMUL, GEMM: begin
        cfg_d.stage1_op  = FMADD;
        cfg_d.stage1_rnd = RNE;
        cfg_d.stage2_rnd = RNE;
      end
      ADDMAX: begin
        cfg_d.stage1_op  = ADD;
        cfg_d.stage1_rnd = RNE;
        cfg_d.stage2_rnd = RTZ;
      end
      ADDMIN: begin
        cfg_d.stage1_op  = ADD;
        cfg_d.stage1_rnd = RNE;
        cfg_d.stage2_rnd = RNE;
      end
      MULMAX: begin
        cfg_d.stage1_op  = MUL;
        cfg_d.stage1_rnd = RNE;
        cfg_d.stage2_rnd = RTZ;
      end
      MULMIN: begin
        cfg_d.stage1_op  = MUL;
        cfg_d.stage1_rnd = RNE;
        cfg_d.stage2_rnd = RNE;
      end
      MAXMIN: begin
        cfg_d.stage1_op  = MINMAX;
        cfg_d.stage1_rnd = RTZ;
        cfg_d.stage2_rnd = RNE;
      end
      default: begin
        cfg_d.stage1_op  = MINMAX;
        cfg_d.stage1_rnd = RNE;
        cfg_d.stage2_rnd = RTZ;
      end
    endcase

    cfg_d.z_addr = job_i.z_addr;
  end

  assign load_cfg = x_read_valid_q && w_len_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_cols_valid_q <= 1'b0;
      x_read_valid_q    <= 1'b0;
      w_len_valid_q     <= 1'b0;
      cfg_valid_q       <= 1'b0;
    end else if (clear_i) begin
      rows_cols_valid_q <= 1'b0;
      x_read_valid_q    <= 1'b0;
      w_len_valid_q     <= 1'b0;
      cfg_valid_q       <= 1'b0;
    end else begin
      rows_cols_valid_q <= start_i;
      x_read_valid_q    <= rows_cols_valid_q;
      w_len_valid_q     <= rows_cols_valid_q;
      cfg_valid_q       <= load_cfg;
    end
  end

  // First stage rows by cols, second stage the two triple products
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rows_cols_q <= 32'(cfg_d.x_rows_iter) * 32'(cfg_d.w_cols_iter);
    end
    if (rows_cols_valid_q) begin
      x_read_q <= rows_cols_q * 32'(cfg_d.x_cols_iter);
      w_len_q  <= rows_cols_q * 32'(cfg_d.w_rows_iter);
    end
  end

  // Result register held until the next job
  always_ff @(posedge clk_i) begin
    if (load_cfg) begin
      cfg_q <= cfg_d;
    end
  end

  assign cfg_valid_o = cfg_valid_q;
  assign cfg_o       = cfg_q;

  // Result only three cycles after a start
  a_valid_after_start: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(cfg_valid_o) |-> $past(start_i, 3)
  );

endmodule

//--- src.f
+incdir+.
gemm_pkg.sv
gemm_cfg_regs.sv
gemm_tiler.sv
gemm_store_walker.sv
gemm_ctrl_top.sv
tb_gemm_ctrl.sv

//--- gemm_ctrl_model.svh
// GEMM controller reference model for tiling, operation decode and store addresses
`ifndef GEMM_CTRL_MODEL_SVH
`define GEMM_CTRL_MODEL_SVH

function automatic tile_cfg_t model_tile_cfg(input job_regs_t j);
  tile_cfg_t c;
  int        m;
  int        n;
  int        k;
  int        eb;
  int        tot;
  m = int'(j.m_size);
  n = int'(j.n_size);
  k = int'(j.k_size);
  c = '0;
  // Ceiling divisions and remainders per dimension
  c.x_rows_iter    = 16'((m + `ARRAY_WIDTH - 1) / `ARRAY_WIDTH);
  c.x_rows_lftovr  = 8'(m % `ARRAY_WIDTH);
  c.x_cols_iter    = 16'((n + `COL_CHUNK - 1) / `COL_CHUNK);
  c.x_cols_lftovr  = 8'(n % `COL_CHUNK);
  c.w_cols_iter    = 16'((k + `COL_CHUNK - 1) / `COL_CHUNK);
  c.w_cols_lftovr  = 8'(k % `COL_CHUNK);
  c.w_rows_lftovr  = 8'(n % `ARRAY_HEIGHT);
  c.w_rows_iter    = 16'(((n + `ARRAY_HEIGHT - 1) / `ARRAY_HEIGHT) * `ARRAY_HEIGHT);
  c.x_buffer_slots = 16'((((n % `COL_CHUNK) + `ARRAY_HEIGHT - 1) / `ARRAY_HEIGHT) * `ARRAY_HEIGHT);
  tot              = int'(c.x_rows_iter) * int'(c.w_cols_iter);
  c.tot_stores     = 16'(tot);
  c.tot_x_read     = 32'(tot * int'(c.x_cols_iter));
  c.w_tot_len      = 32'(tot * int'(c.w_rows_iter));
  c.z_tot_len      = 32'(`ARRAY_WIDTH * tot);
  eb               = (j.fmt == FP16 || j.fmt == FP16ALT) ? 2 : 1;
  c.elem_bytes     = 2'(eb);
  c.x_d1_stride    = 32'(n * eb);
  c.x_rows_offs    = 32'(`ARRAY_WIDTH * n * eb);
  c.w_d0_stride    = 32'(k * eb);
  c.z_d2_stride    = 32'(`ARRAY_WIDTH * k * eb);
  c.stage2_op      = MINMAX;
  c.gemm_sel       = (j.gemm_op != MATMUL);
  c.stage1_rnd     = (j.gemm_op == MAXMIN) ? RTZ : RNE;
  c.stage2_rnd     = (j.gemm_op == ADDMAX || j.gemm_op == MULMAX) ? RTZ : RNE;
  case (j.gemm_op)
    ADDMAX, ADDMIN: c.stage1_op = ADD;
    MULMAX, MULMIN: c.stage1_op = MUL;
    MAXMIN:         c.stage1_op = MINMAX;
    default:        c.stage1_op = FMADD;
  endcase
  c.z_addr = j.z_addr;
  return c;
endfunction

// Descriptor number idx of the row-major store stream
function automatic store_desc_t model_store(input tile_cfg_t c, input int idx);
  store_desc_t s;
  int          cols;
  int          row;
  int          col;
  cols      = int'(c.w_cols_iter);
  row       = idx / cols;
  col       = idx % cols;
  s.row_idx = 16'(row);
  s.col_idx = 16'(col);
  s.addr    = c.z_addr + 32'(row) * c.z_d2_stride + 32'(col * `COL_CHUNK * int'(c.elem_bytes));
  s.last    = (idx == int'(c.tot_stores) - 1);
  return s;
endfunction

`endif

//--- tb_gemm_ctrl.sv
// GEMM controller testbench driving random jobs and checking them against a reference model
`timescale 1ns/1ps
`include "gemm_consts.svh"

module tb_gemm_ctrl
  import gemm_pkg::*;
();

  localparam int WatchLimit = 100;

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  logic        reg_we_i;
  logic [3:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic        cfg_valid_o;
  tile_cfg_t   cfg_o;
  logic        store_valid_o;
  store_desc_t store_o;
  logic        done_o;
  logic        busy_o;

  string       test_name;
  int          err_count;
  int          test_errs;
  int          tests_run;
  int          tests_failed;

  `include "gemm_ctrl_model.svh"

  gemm_ctrl_top i_gemm_ctrl_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .reg_we_i      (reg_we_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .cfg_valid_o   (cfg_valid_o),
    .cfg_o         (cfg_o),
    .store_valid_o (store_valid_o),
    .store_o       (store_o),
    .done_o        (done_o),
    .busy_o        (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic compare_cfg(input tile_cfg_t exp);
    check_value("x_rows_iter", 32'(exp.x_rows_iter), 32'(cfg_o.x_rows_iter));
    check_value("x_cols_iter", 32'(exp.x_cols_iter), 32'(cfg_o.x_cols_iter));
    check_value("w_rows_iter", 32'(exp.w_rows_iter), 32'(cfg_o.w_rows_iter));
    check_value("w_cols_iter", 32'(exp.w_cols_iter), 32'(cfg_o.w_cols_iter));
    check_value("x_rows_lftovr", 32'(exp.x_rows_lftovr), 32'(cfg_o.x_rows_lftovr));
    check_value("x_cols_lftovr", 32'(exp.x_cols_lftovr), 32'(cfg_o.x_cols_lftovr));
    check_value("w_rows_lftovr", 32'(exp.w_rows_lftovr), 32'(cfg_o.w_rows_lftovr));
    check_value("w_cols_lftovr", 32'(exp.w_cols_lftovr), 32'(cfg_o.w_cols_lftovr));
    check_value("x_buffer_slots", 32'(exp.x_buffer_slots), 32'(cfg_o.x_buffer_slots));
    check_value("tot_stores", 32'(exp.tot_stores), 32'(cfg_o.tot_stores));
    check_value("tot_x_read", exp.tot_x_read, cfg_o.tot_x_read);
    check_value("w_tot_len", exp.w_tot_len, cfg_o.w_tot_len);
    check_value("z_tot_len", exp.z_tot_len, cfg_o.z_tot_len);
    check_value("x_d1_stride", exp.x_d1_stride, cfg_o.x_d1_stride);
    check_value("x_rows_offs", exp.x_rows_offs, cfg_o.x_rows_offs);
    check_value("w_d0_stride", exp.w_d0_stride, cfg_o.w_d0_stride);
    check_value("z_d2_stride", exp.z_d2_stride, cfg_o.z_d2_stride);
    check_value("stage1_op", 32'(exp.stage1_op), 32'(cfg_o.stage1_op));
    check_value("stage2_op", 32'(exp.stage2_op), 32'(cfg_o.stage2_op));
    check_value("stage1_rnd", 32'(exp.stage1_rnd), 32'(cfg_o.stage1_rnd));
    check_value("stage2_rnd", 32'(exp.stage2_rnd), 32'(cfg_o.stage2_rnd));
    check_value("elem_bytes", 32'(exp.elem_bytes), 32'(cfg_o.elem_bytes));
    check_value("gemm_sel", 32'(exp.gemm_sel), 32'(cfg_o.gemm_sel));
    check_value("z_addr", exp.z_addr, cfg_o.z_addr);
  endtask

  // Register word idx as the host writes it for job j
  function automatic logic [31:0] job_word(input job_regs_t j, input int idx);
    case (idx)
      `REG_X_ADDR: return j.x_addr;
      `REG_W_ADDR: return j.w_addr;
      `REG_Z_ADDR: return j.z_addr;
      `REG_MCFG0:  return {j.k_size, j.m_size};
      `REG_MCFG1:  return {16'h0, j.n_size};
      default:     return {19'h0, j.gemm_op, j.fmt, 7'h0};
    endcase
  endfunction

  function automatic job_regs_t random_job(input int m_lo, input int k_lo);
    job_regs_t j;
    j.x_addr  = $urandom;
    j.w_addr  = $urandom;
    j.z_addr  = $urandom;
    j.m_size  = 16'($urandom_range(60, m_lo));
    j.k_size  = 16'($urandom_range(60, k_lo));
    j.n_size  = 16'($urandom_range(60, 1));
    j.gemm_op = gemm_op_e'(3'($urandom_range(6, 0)));
    j.fmt     = gemm_fmt_e'(3'($urandom_range(3, 0)));
    return j;
  endfunction

  // Write stays on the bus until the next drive slot
  task automatic write_reg(input int idx, input logic [31:0] data);
    @(posedge clk_i);
    #2;
    reg_we_i    = 1'b1;
    reg_addr_i  = 4'(idx);
    reg_wdata_i = data;
  endtask

  task automatic load_job(input job_regs_t j);
    for (int idx = 0; idx < `REG_TRIGGER; idx++) begin
      write_reg(idx, job_word(j, idx));
    end
  endtask

  task automatic trigger_job();
    write_reg(`REG_TRIGGER, $urandom);
  endtask

  // Cycle 0 is the trigger cycle, outputs sampled at the falling edge
  task automatic watch_job(input job_regs_t j, input bit iso, input job_regs_t nxt,
                           input int clear_at);
    tile_cfg_t   exp;
    store_desc_t exp_st;
    int          cyc;
    int          n_st;
    bit          done_seen;
    bit          finished;
    exp       = model_tile_cfg(j);
    cyc       = 0;
    n_st      = 0;
    done_seen = 1'b0;
    finished  = 1'b0;
    while (!finished && cyc < WatchLimit) begin
      @(negedge clk_i);
      if (cfg_valid_o) begin
        check_value("cfg_valid cycle", 32'd4, 32'(cyc));
        compare_cfg(exp);
      end
      if (store_valid_o) begin
        if (n_st == 0) begin
          check_value("first store cycle", 32'd5, 32'(cyc));
        end
        exp_st = model_store(exp, n_st);
        check_value("store addr", exp_st.addr, store_o.addr);
        check_value("store row", 32'(exp_st.row_idx), 32'(store_o.row_idx));
        check_value("store col", 32'(exp_st.col_idx), 32'(store_o.col_idx));
        check_value("store last", 32'(exp_st.last), 32'(store_o.last));
        check_value("busy during store", 32'd1, 32'(busy_o));
        n_st++;
      end
      if (clear_at >= 0) begin
        if (cyc > clear_at) begin
          check_value("outputs after clear", 32'd0, 32'({store_valid_o, busy_o, done_o}));
        end
        finished = (cyc == clear_at + 3);
      end else if (done_seen) begin
        check_value("done pulse width", 32'd0, 32'(done_o));
        finished = 1'b1;
      end else if (done_o) begin
        done_seen = 1'b1;
        check_value("busy at done", 32'd0, 32'(busy_o));
        check_value("store count", 32'(exp.tot_stores), 32'(n_st));
        compare_cfg(exp);
      end
      @(posedge clk_i);
      #2;
      reg_we_i = 1'b0;
      clear_i  = 1'b0;
      // New job words land while the walker is busy
      if (iso && cyc >= 5 && cyc < 5 + `REG_TRIGGER) begin
        reg_we_i    = 1'b1;
        reg_addr_i  = 4'(cyc - 5);
        reg_wdata_i = job_word(nxt, cyc - 5);
      end
      if (clear_at >= 0 && cyc + 1 == clear_at) begin
        clear_i = 1'b1;
      end
      cyc++;
    end
    if (!finished) begin
      $display("%s: timeout, the job did not finish within %0d cycles", test_name, WatchLimit);
      err_count++;
    end
  endtask

  task automatic run_job(input job_regs_t j);
    load_job(j);
    trigger_job();
    watch_job(j, 1'b0, j, -1);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count == test_errs) begin
      $display("PASS %s", test_name);
    end else begin
      tests_failed++;
      $display("FAIL %s", test_name);
    end
  endtask

  initial begin
    job_regs_t j;
    job_regs_t nxt;
    void'($urandom(32'hbd834990));
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    reg_we_i     = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    err_count    = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "reset";
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (int i = 0; i < 20; i++) begin
      begin_test($sformatf("random_job_%0d", i));
      j = random_job(1, 1);
      run_job(j);
      end_test();
    end

    // Every operation once, with the format stepping along
    for (int op = 0; op < 7; op++) begin
      j         = random_job(1, 1);
      j.gemm_op = gemm_op_e'(3'(op));
      j.fmt     = gemm_fmt_e'(3'(op % 4));
      begin_test($sformatf("op_%s", j.gemm_op.name()));
      run_job(j);
      end_test();
    end

    // Large first job keeps the walker busy during the writes
    j   = random_job(49, 33);
    nxt = random_job(1, 1);
    begin_test("isolation_busy");
    load_job(j);
    trigger_job();
    watch_job(j, 1'b1, nxt, -1);
    end_test();
    begin_test("isolation_next");
    trigger_job();
    watch_job(nxt, 1'b0, nxt, -1);
    end_test();

    j = random_job(49, 33);
    begin_test("clear_mid_job");
    load_job(j);
    trigger_job();
    watch_job(j, 1'b0, j, 8);
    end_test();
    j = random_job(1, 1);
    begin_test("after_clear");
    run_job(j);
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
